//--- decodePkg.sv
// Micro-step decoder definitions
`default_nettype none

package decodePkg;

    localparam int STEP_W    = 4;  // step counter width.
    localparam int ITABLE_W  = 8;  // table code width.
    localparam int REG_SEL_W = 3;  // B C D E H L - A.
    localparam int GROUP_BIT = 3;  // picks the half-decoder.

    // table code fields
    localparam int CLS_W = 4;  // class in bits 7..4.
    localparam int ARG_W = 3;  // argument in bits 2..0.

    // step numbers used by the step tables
    localparam logic [STEP_W-1:0] STEP_0 = 4'd0;
    localparam logic [STEP_W-1:0] STEP_1 = 4'd1;
    localparam logic [STEP_W-1:0] STEP_2 = 4'd2;

    typedef enum logic [CLS_W-1:0] {
        CLS_NOP     = 4'd0,
        CLS_LD_R_N  = 4'd1,
        CLS_LD_A_NN = 4'd2,
        CLS_LD_NN_A = 4'd3,
        CLS_ALU_R   = 4'd4
    } instrClassE;

    // the branch group reuses the low class codes.
    localparam instrClassE CLS_JP_NN    = instrClassE'(4'd0);
    localparam instrClassE CLS_JP_CC_NN = instrClassE'(4'd1);

    typedef enum logic [ARG_W-1:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } aluOpE;

    typedef enum logic [ARG_W-1:0] {
        CC_NZ, CC_Z, CC_NC, CC_C,
        CC_PO, CC_PE, CC_P, CC_M
    } condE;

    typedef enum logic {
        ADDR_PC = 1'b0,  // program counter.
        ADDR_NN = 1'b1   // collected operand address.
    } addrSelE;

endpackage

`default_nettype wire

//--- baseDecoder.sv
// Base group half-decoder
`timescale 1ns/10ps
`default_nettype none

module baseDecoder (
    input  wire                                 en,
    input  wire  [decodePkg::STEP_W-1:0]        xpt,
    input  wire  [decodePkg::ITABLE_W-1:0]      itable,
    output logic                                memRead,
    output logic                                memWrite,
    output decodePkg::addrSelE                  addrSel,
    output logic                                regWrite,
    output logic [decodePkg::REG_SEL_W-1:0]     regSel,
    output logic                                aluStrobe,
    output decodePkg::aluOpE                    aluOp,
    output logic                                writeA,
    output logic                                flagWrite,
    output logic                                writePc,
    output logic                                stepReset,
    output logic                                fetchNext
);

    decodePkg::instrClassE       cls;
    logic [decodePkg::ARG_W-1:0] arg;
    decodePkg::aluOpE            op;
    logic                        done;

    assign cls = decodePkg::instrClassE'(
        itable[decodePkg::ITABLE_W-1 -: decodePkg::CLS_W]);
    assign arg = itable[decodePkg::ARG_W-1:0];
    assign op  = decodePkg::aluOpE'(arg);

    always_comb begin
        memRead   = 1'b0;
        memWrite  = 1'b0;
        addrSel   = decodePkg::ADDR_PC;
        regWrite  = 1'b0;
        regSel    = '0;
        aluStrobe = 1'b0;
        aluOp     = decodePkg::ALU_ADD;
        writeA    = 1'b0;
        flagWrite = 1'b0;
        done      = 1'b0;

        if (en) begin
            case (cls)
                decodePkg::CLS_NOP: begin
                    done = 1'b1;
                end

                decodePkg::CLS_LD_R_N: begin
                    if (xpt == decodePkg::STEP_0) begin
                        memRead = 1'b1;  // immediate byte.
                    end else begin
                        regWrite = 1'b1;
                        regSel   = arg;
                        done     = 1'b1;
                    end
                end

                decodePkg::CLS_LD_A_NN: begin
                    memRead = 1'b1;
                    if (xpt >= decodePkg::STEP_2) begin
                        addrSel = decodePkg::ADDR_NN;  // data from (nn).
                        writeA  = 1'b1;
                        done    = 1'b1;
                    end
                end

                decodePkg::CLS_LD_NN_A: begin
                    if (xpt < decodePkg::STEP_2) begin
                        memRead = 1'b1;  // nn low then high.
                    end else begin
                        memWrite = 1'b1;
                        addrSel  = decodePkg::ADDR_NN;
                        done     = 1'b1;
                    end
                end

                decodePkg::CLS_ALU_R: begin
                    aluStrobe = 1'b1;
                    aluOp     = op;
                    flagWrite = 1'b1;
                    writeA    = (op != decodePkg::ALU_CP);  // compare keeps A.
                    done      = 1'b1;
                end

                default: begin
                    done = 1'b1;  // undefined, single step.
                end
            endcase
        end
    end

    // jumps are decoded in the branch half.
    assign writePc   = 1'b0;
    assign stepReset = done;
    assign fetchNext = done;

endmodule

`default_nettype wire

//--- branchDecoder.sv
// Branch group half-decoder
`timescale 1ns/10ps
`default_nettype none

module branchDecoder (
    input  wire                                 en,
    input  wire  [decodePkg::STEP_W-1:0]        xpt,
    input  wire  [decodePkg::ITABLE_W-1:0]      itable,
    input  wire                                 flagC,
    input  wire                                 flagZ,
    input  wire                                 flagPV,
    input  wire                                 flagS,
    output logic                                memRead,
    output logic                                memWrite,
    output decodePkg::addrSelE                  addrSel,
    output logic                                regWrite,
    output logic [decodePkg::REG_SEL_W-1:0]     regSel,
    output logic                                aluStrobe,
    output decodePkg::aluOpE                    aluOp,
    output logic                                writeA,
    output logic                                flagWrite,
    output logic                                writePc,
    output logic                                stepReset,
    output logic                                fetchNext
);

    decodePkg::instrClassE cls;
    decodePkg::condE       cond;
    logic                  condTrue;
    logic                  done;

    assign cls  = decodePkg::instrClassE'(
        itable[decodePkg::ITABLE_W-1 -: decodePkg::CLS_W]);
    assign cond = decodePkg::condE'(itable[decodePkg::ARG_W-1:0]);

    always_comb begin
        case (cond)
            decodePkg::CC_NZ: condTrue = ~flagZ;
            decodePkg::CC_Z:  condTrue = flagZ;
            decodePkg::CC_NC: condTrue = ~flagC;
            decodePkg::CC_C:  condTrue = flagC;
            decodePkg::CC_PO: condTrue = ~flagPV;
            decodePkg::CC_PE: condTrue = flagPV;
            decodePkg::CC_P:  condTrue = ~flagS;
            default:          condTrue = flagS;  // M.
        endcase
    end

    always_comb begin
        memRead = 1'b0;
        writePc = 1'b0;
        done    = 1'b0;

        if (en) begin
            if (cls == decodePkg::CLS_JP_NN || cls == decodePkg::CLS_JP_CC_NN) begin
                if (xpt < decodePkg::STEP_2) begin
                    memRead = 1'b1;  // target low then high.
                end else begin
                    writePc = (cls == decodePkg::CLS_JP_NN) | condTrue;
                    done    = 1'b1;  // false condition still ends here.
                end
            end else begin
                done = 1'b1;
            end
        end
    end

    // jumps never touch data memory, registers or the ALU.
    assign memWrite  = 1'b0;
    assign addrSel   = decodePkg::ADDR_PC;
    assign regWrite  = 1'b0;
    assign regSel    = '0;
    assign aluStrobe = 1'b0;
    assign aluOp     = decodePkg::ALU_ADD;
    assign writeA    = 1'b0;
    assign flagWrite = 1'b0;
    assign stepReset = done;
    assign fetchNext = done;

endmodule

`default_nettype wire

//--- instrDecoder.sv
// Instruction decoder top level
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire                                 decodeEn,
    input  wire  [decodePkg::ITABLE_W-1:0]      itable,
    input  wire                                 flagC,
    input  wire                                 flagZ,
    input  wire                                 flagPV,
    input  wire                                 flagS,
    output logic                                memRead,
    output logic                                memWrite,
    output decodePkg::addrSelE                  addrSel,
    output logic                                regWrite,
    output logic [decodePkg::REG_SEL_W-1:0]     regSel,
    output logic                                aluStrobe,
    output decodePkg::aluOpE                    aluOp,
    output logic                                writeA,
    output logic                                flagWrite,
    output logic                                writePc,
    output logic                                stepReset,
    output logic                                fetchNext
);

    logic [decodePkg::STEP_W-1:0]    xpt;
    logic                            baseEn;
    logic                            branchEn;

    logic                            bMemRead,   jMemRead;
    logic                            bMemWrite,  jMemWrite;
    decodePkg::addrSelE              bAddrSel,   jAddrSel;
    logic                            bRegWrite,  jRegWrite;
    logic [decodePkg::REG_SEL_W-1:0] bRegSel,    jRegSel;
    logic                            bAluStrobe, jAluStrobe;
    decodePkg::aluOpE                bAluOp,     jAluOp;
    logic                            bWriteA,    jWriteA;
    logic                            bFlagWrite, jFlagWrite;
    logic                            bWritePc,   jWritePc;
    logic                            bStepReset, jStepReset;
    logic                            bFetchNext, jFetchNext;

    assign baseEn   = decodeEn & ~itable[decodePkg::GROUP_BIT];
    assign branchEn = decodeEn &  itable[decodePkg::GROUP_BIT];

    // step counter restarts on the last step or when idle.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            xpt <= '0;
        end else if (!decodeEn || stepReset) begin
            xpt <= '0;
        end else begin
            xpt <= xpt + 1'b1;
        end
    end

    baseDecoder uBase (
        .en        (baseEn),
        .xpt       (xpt),
        .itable    (itable),
        .memRead   (bMemRead),
        .memWrite  (bMemWrite),
        .addrSel   (bAddrSel),
        .regWrite  (bRegWrite),
        .regSel    (bRegSel),
        .aluStrobe (bAluStrobe),
        .aluOp     (bAluOp),
        .writeA    (bWriteA),
        .flagWrite (bFlagWrite),
        .writePc   (bWritePc),
        .stepReset (bStepReset),
        .fetchNext (bFetchNext)
    );

    branchDecoder uBranch (
        .en        (branchEn),
        .xpt       (xpt),
        .itable    (itable),
        .flagC     (flagC),
        .flagZ     (flagZ),
        .flagPV    (flagPV),
        .flagS     (flagS),
        .memRead   (jMemRead),
        .memWrite  (jMemWrite),
        .addrSel   (jAddrSel),
        .regWrite  (jRegWrite),
        .regSel    (jRegSel),
        .aluStrobe (jAluStrobe),
        .aluOp     (jAluOp),
        .writeA    (jWriteA),
        .flagWrite (jFlagWrite),
        .writePc   (jWritePc),
        .stepReset (jStepReset),
        .fetchNext (jFetchNext)
    );

    // idle half drives zeros, so a plain OR merges them.
    assign memRead   = bMemRead   | jMemRead;
    assign memWrite  = bMemWrite  | jMemWrite;
    assign addrSel   = decodePkg::addrSelE'(bAddrSel | jAddrSel);
    assign regWrite  = bRegWrite  | jRegWrite;
    assign regSel    = bRegSel    | jRegSel;
    assign aluStrobe = bAluStrobe | jAluStrobe;
    assign aluOp     = decodePkg::aluOpE'(bAluOp | jAluOp);
    assign writeA    = bWriteA    | jWriteA;
    assign flagWrite = bFlagWrite | jFlagWrite;
    assign writePc   = bWritePc   | jWritePc;
    assign stepReset = bStepReset | jStepReset;
    assign fetchNext = bFetchNext | jFetchNext;

endmodule

`default_nettype wire

//--- instrDecoderTb.sv
// Instruction decoder testbench
`timescale 1ns/10ps
`default_nettype none

module instrDecoderTb;

    localparam int          DEPTH     = 256;  // pattern memory words.
    localparam int          HALF      = 5;    // half clock period.
    localparam int          RESET_CYC = 3;
    localparam logic [31:0] END_WORD  = 32'h8000_0000;

    logic                                clk;
    logic                                rstN;
    logic                                decodeEn;
    logic [decodePkg::ITABLE_W-1:0]      itable;
    logic                                flagC;
    logic                                flagZ;
    logic                                flagPV;
    logic                                flagS;

    logic                                memRead;
    logic                                memWrite;
    decodePkg::addrSelE                  addrSel;
    logic                                regWrite;
    logic [decodePkg::REG_SEL_W-1:0]     regSel;
    logic                                aluStrobe;
    decodePkg::aluOpE                    aluOp;
    logic                                writeA;
    logic                                flagWrite;
    logic                                writePc;
    logic                                stepReset;
    logic                                fetchNext;

    logic [31:0] vectors [DEPTH];
    int          numVec;
    int          cycles = 0;
    int          limit  = 0;

    instrDecoder uut (
        .clk       (clk),
        .rstN      (rstN),
        .decodeEn  (decodeEn),
        .itable    (itable),
        .flagC     (flagC),
        .flagZ     (flagZ),
        .flagPV    (flagPV),
        .flagS     (flagS),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addrSel   (addrSel),
        .regWrite  (regWrite),
        .regSel    (regSel),
        .aluStrobe (aluStrobe),
        .aluOp     (aluOp),
        .writeA    (writeA),
        .flagWrite (flagWrite),
        .writePc   (writePc),
        .stepReset (stepReset),
        .fetchNext (fetchNext)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    // watchdog on the whole run.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout, the pattern list did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %s at vector %0d: got 0x%0h, expected 0x%0h", name, idx, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // field order matches the expected word of the pattern file.
    task automatic checkOutputs(input logic [15:0] exp, input int idx);
        checkValue("memRead",   16'(memRead),   16'(exp[15]),   idx);
        checkValue("memWrite",  16'(memWrite),  16'(exp[14]),   idx);
        checkValue("addrSel",   16'(addrSel),   16'(exp[13]),   idx);
        checkValue("regWrite",  16'(regWrite),  16'(exp[12]),   idx);
        checkValue("regSel",    16'(regSel),    16'(exp[11:9]), idx);
        checkValue("aluStrobe", 16'(aluStrobe), 16'(exp[8]),    idx);
        checkValue("aluOp",     16'(aluOp),     16'(exp[7:5]),  idx);
        checkValue("writeA",    16'(writeA),    16'(exp[4]),    idx);
        checkValue("flagWrite", 16'(flagWrite), 16'(exp[3]),    idx);
        checkValue("writePc",   16'(writePc),   16'(exp[2]),    idx);
        checkValue("stepReset", 16'(stepReset), 16'(exp[1]),    idx);
        checkValue("fetchNext", 16'(fetchNext), 16'(exp[0]),    idx);
    endtask

    initial begin
        int          i;
        logic [31:0] word;

        rstN     = 1'b0;
        decodeEn = 1'b0;
        itable   = '0;
        flagC    = 1'b0;
        flagZ    = 1'b0;
        flagPV   = 1'b0;
        flagS    = 1'b0;

        for (i = 0; i < DEPTH; i++) begin
            vectors[i] = '0;
        end
        $readmemh("decodePatterns.txt", vectors);

        numVec = -1;
        for (i = 0; i < DEPTH && numVec < 0; i++) begin
            if (vectors[i] == END_WORD) begin
                numVec = i;
            end
        end
        if (numVec < 0) begin
            $display("the pattern file has no end marker");
            $display("TESTS FAILED");
            $fatal(1);
        end
        limit = 2 * numVec + 20;

        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (i = 0; i < numVec; i++) begin
            word = vectors[i];
            @(negedge clk);
            decodeEn                        = word[28];
            itable                          = word[27:20];
            {flagS, flagPV, flagZ, flagC}   = word[19:16];
            #(HALF - 1);  // just ahead of the rising edge.
            checkOutputs(word[15:0], i);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- decodePatterns.txt
// one word per cycle: [28] decodeEn, [27:20] itable, [19:16] flags S PV Z C, [15:0] expected
// memRead memWrite addrSel regWrite regSel aluStrobe aluOp writeA flagWrite writePc stepReset fetchNext
// idle after reset, also with junk on itable and flags
00000000 04FF0000 018F0000
// NOP back to back
10000003 10000003
// ALU ADD ADC SUB SBC AND XOR OR CP back to back
1400011B 1410013B 1420015B 1430017B
1440019B 145001BB 146001DB 147001EB
// mixed one-step instructions
10000003 147001EB 145F01BB
// LD r,n into B, C, L and A
11008000 11001003
11108000 11101203
11508000 11501A03
11708000 11701E03
// LD A,(nn)
12008000 12008000 1200A013
// LD (nn),A
13008000 13008000 13006003
// JP nn, flags have no effect
10808000 10808000 10800007
108F8000 108F8000 108F0007
// JP NZ taken, then not taken
11808000 11808000 11800007
11828000 11828000 11820003
// JP Z
11928000 11928000 11920007
119D8000 119D8000 119D0003
// JP NC
11AE8000 11AE8000 11AE0007
11A18000 11A18000 11A10003
// JP C
11B18000 11B18000 11B10007
11B08000 11B08000 11B00003
// JP PO
11CB8000 11CB8000 11CB0007
11C48000 11C48000 11C40003
// JP PE
11D48000 11D48000 11D40007
11DB8000 11DB8000 11DB0003
// JP P
11E78000 11E78000 11E70007
11E88000 11E88000 11E80003
// JP M
11F88000 11F88000 11F80007
11F78000 11F78000 11F70003
// undefined base classes
15000003 1F700003
// undefined branch classes
12800003 1F8F0003
// decodeEn dropped mid-instruction, next one restarts at step 0
12008000 12008000 02000000 12008000 12008000 1200A013
10808000 00800000 10808000 10808000 10800007
11708000 01700000 11708000 11701E03
// idle, then end of list
00000000
80000000

//--- verilog.f
decodePkg.sv
baseDecoder.sv
branchDecoder.sv
instrDecoder.sv
instrDecoderTb.sv

//--- Makefile
TOP := instrDecoderTb
SRCS := decodePkg.sv baseDecoder.sv branchDecoder.sv instrDecoder.sv instrDecoderTb.sv

all: run

run: obj_dir/V$(TOP) decodePatterns.txt
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(SRCS)
	verilator --binary --timescale 1ns/10ps -Wno-fatal --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/10ps --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
